/* list.f */
rtl/vec_width_pkg.sv
rtl/valu_isa_pkg.sv
rtl/valu_req_if.sv
rtl/valu_decoder.sv
rtl/simd_lane.sv
rtl/valu_execute.sv
rtl/valu_result.sv
rtl/valu_top.sv
tb/tb_clock_gen.sv
tb/tb_valu.sv

/* rtl/simd_lane.sv */
// SIMD lane with multiplier, adder/subtractor, SEW-narrowed shifter and result select
module simd_lane import valu_isa_pkg::*; import vec_width_pkg::*; #(
  parameter int unsigned Width = 32
) (
  input  op_e              operation_i,
  input  logic             operation_valid_i,
  input  logic [Width-1:0] op_s1_i,
  input  logic [Width-1:0] op_s2_i,
  input  logic [Width-1:0] op_d_i,
  input  logic             is_signed_i,
  input  logic             carry_i,
  input  vew_e             sew_i,
  output logic [Width-1:0] result_o
);

  localparam int unsigned ShiftWidth = $clog2(Width);

  // Active element size, never wider than the lane
  int unsigned sew_width;
  assign sew_width = (sew_bits(sew_i) > Width) ? Width : sew_bits(sew_i);

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  logic               is_mult;
  logic [Width-1:0]   mult_op1;
  logic [Width-1:0]   mult_op2;
  logic               mult_sign1;
  logic               mult_sign2;
  logic [2*Width-1:0] mult_result;
  logic [Width-1:0]   mulh_result;

  assign is_mult = operation_valid_i &&
                   (operation_i inside {VMUL, VMULH, VMULHU, VMULHSU,
                                        VMACC, VNMSAC, VMADD, VNMSUB});

  always_comb begin : mult_operands
    mult_op1 = op_s1_i;
    mult_op2 = op_s2_i;
    // Destination forms multiply by the accumulator
    if (operation_i inside {VMADD, VNMSUB}) begin
      mult_op2 = op_d_i;
    end
    // Quiet inputs when idle
    if (!is_mult) begin
      mult_op1 = '0;
      mult_op2 = '0;
    end
  end

  // VMULHSU treats s1 as signed and s2 as unsigned
  assign mult_sign1  = mult_op1[Width-1] & is_signed_i;
  assign mult_sign2  = mult_op2[Width-1] & is_signed_i & (operation_i != VMULHSU);
  assign mult_result = $signed({mult_sign1, mult_op1}) * $signed({mult_sign2, mult_op2});

  // High half taken at the SEW boundary
  assign mulh_result = Width'(mult_result >> sew_width);

  ////////////////////////////////////////////////////////////
  // Adder / subtractor
  ////////////////////////////////////////////////////////////

  logic [Width-1:0] arith_a;   // Subtrahend
  logic [Width-1:0] arith_b;   // Minuend
  logic [Width:0]   sum;
  logic [Width:0]   diff;

  always_comb begin : arith_operands
    unique case (operation_i)
      VMACC, VNMSAC: begin
        arith_a = mult_result[Width-1:0];
        arith_b = op_d_i;
      end
      VMADD, VNMSUB: begin
        arith_a = mult_result[Width-1:0];
        arith_b = op_s2_i;
      end
      VRSUB: begin
        arith_a = op_s2_i;
        arith_b = op_s1_i;
      end
      default: begin
        arith_a = op_s1_i;
        arith_b = op_s2_i;
      end
    endcase
  end

  // Bit Width holds carry-out or borrow-out
  assign sum  = {1'b0, arith_b} + {1'b0, arith_a} + (Width+1)'(carry_i);
  assign diff = {1'b0, arith_b} - {1'b0, arith_a} - (Width+1)'(carry_i);

  // Signed or unsigned compare for min and max
  logic s1_lt_s2;
  assign s1_lt_s2 = $signed({op_s1_i[Width-1] & is_signed_i, op_s1_i}) <
                    $signed({op_s2_i[Width-1] & is_signed_i, op_s2_i});

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  logic [ShiftWidth-1:0] shift_amount;
  logic [Width-1:0]      shift_mask;
  logic                  shift_msb;
  logic [Width-1:0]      shift_operand;

  always_comb begin : shift_operands
    shift_mask    = {Width{1'b1}} >> (Width - sew_width);
    shift_amount  = op_s1_i[ShiftWidth-1:0] & ShiftWidth'(sew_width - 1);
    // Sign extend from SEW for arithmetic right shifts only
    shift_msb     = op_s2_i[sew_width-1] & (operation_i == VSRA);
    shift_operand = (op_s2_i & shift_mask) | ({Width{shift_msb}} & ~shift_mask);
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin : result_select
    result_o = '0;
    if (operation_valid_i) begin
      unique case (operation_i)
        VADD, VADC, VMACC, VMADD:          result_o = sum[Width-1:0];
        VSUB, VRSUB, VSBC, VNMSAC, VNMSUB: result_o = diff[Width-1:0];
        VMADC:                             result_o = Width'(sum[Width]);
        VMSBC:                             result_o = Width'(diff[Width]);
        VMIN, VMINU:                       result_o = s1_lt_s2 ? op_s1_i : op_s2_i;
        VMAX, VMAXU:                       result_o = s1_lt_s2 ? op_s2_i : op_s1_i;
        VAND:                              result_o = op_s1_i & op_s2_i;
        VOR:                               result_o = op_s1_i | op_s2_i;
        VXOR:                              result_o = op_s1_i ^ op_s2_i;
        VSLL:                              result_o = shift_operand << shift_amount;
        VSRL:                              result_o = shift_operand >> shift_amount;
        VSRA:                              result_o = $signed(shift_operand) >>> shift_amount;
        VMUL:                              result_o = mult_result[Width-1:0];
        VMULH, VMULHU, VMULHSU:            result_o = mulh_result;
        default:                           result_o = '0;
      endcase
    end
  end

  // Decode stage filters SEW wider than the lane
  always_comb begin : sew_check
    if (operation_valid_i) begin
      a_sew_fits: assert final (sew_bits(sew_i) <= Width)
        else $error("simd_lane: SEW of %0d bits on a %0d bit lane", sew_bits(sew_i), Width);
    end
  end

endmodule : simd_lane

/* rtl/valu_decoder.sv */
// Decode stage with function code decode, SEW check and request register
module valu_decoder import valu_isa_pkg::*; import vec_width_pkg::*; #(
  parameter int unsigned Width = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [InstrWidth-1:0] instr_i,
  input  logic [Width-1:0]      src1_i,
  input  logic [Width-1:0]      src2_i,
  input  logic                  carry_i,
  valu_req_if.producer          req,
  output logic                  illegal_o
);

  instr_t instr;
  op_e    dec_op;
  vew_e   dec_sew;
  logic   dec_legal;
  logic   dec_signed;
  logic   dec_uses_carry;

  assign instr   = instr_t'(instr_i);
  assign dec_sew = vew_e'(instr.sew);

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin : funct_decode
    case (instr.funct)
      FunctVadd:    dec_op = VADD;
      FunctVsub:    dec_op = VSUB;
      FunctVrsub:   dec_op = VRSUB;
      FunctVadc:    dec_op = VADC;
      FunctVsbc:    dec_op = VSBC;
      FunctVmadc:   dec_op = VMADC;
      FunctVmsbc:   dec_op = VMSBC;
      FunctVmin:    dec_op = VMIN;
      FunctVminu:   dec_op = VMINU;
      FunctVmax:    dec_op = VMAX;
      FunctVmaxu:   dec_op = VMAXU;
      FunctVand:    dec_op = VAND;
      FunctVor:     dec_op = VOR;
      FunctVxor:    dec_op = VXOR;
      FunctVsll:    dec_op = VSLL;
      FunctVsrl:    dec_op = VSRL;
      FunctVsra:    dec_op = VSRA;
      FunctVmul:    dec_op = VMUL;
      FunctVmulh:   dec_op = VMULH;
      FunctVmulhu:  dec_op = VMULHU;
      FunctVmulhsu: dec_op = VMULHSU;
      FunctVmacc:   dec_op = VMACC;
      FunctVnmsac:  dec_op = VNMSAC;
      FunctVmadd:   dec_op = VMADD;
      FunctVnmsub:  dec_op = VNMSUB;
      default:      dec_op = OP_NONE;
    endcase
  end

  // Unsigned forms only; VMULHSU counts as signed, the lane clears the s2 sign
  assign dec_signed     = !(dec_op inside {VMINU, VMAXU, VMULHU});
  assign dec_uses_carry = dec_op inside {VADC, VSBC, VMADC, VMSBC};

  // Known code and an element that fits the lane
  assign dec_legal = (dec_op != OP_NONE) && (sew_bits(dec_sew) <= Width);

  ////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : ctrl_reg
    if (reset_i) begin
      req.valid <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      req.valid <= instr_valid_i & dec_legal;
      illegal_o <= instr_valid_i & ~dec_legal;
    end
  end

  always_ff @(posedge clk_i) begin : payload_reg
    if (instr_valid_i) begin
      req.op        <= dec_op;
      req.sew       <= dec_sew;
      req.is_signed <= dec_signed;
      // Carry-in only reaches the carry forms
      req.carry     <= carry_i & dec_uses_carry;
      req.acc_write <= instr.acc_write;
      req.src1      <= src1_i;
      req.src2      <= src2_i;
    end
  end

  // One response kind per sampled instruction
  a_valid_illegal_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(req.valid && illegal_o)
  ) else $error("valu_decoder: request and illegal strobe together");

endmodule : valu_decoder

/* rtl/valu_execute.sv */
// Execute stage feeding the SIMD lane from the request and the accumulator
module valu_execute import valu_isa_pkg::*; import vec_width_pkg::*; #(
  parameter int unsigned Width = 32
) (
  valu_req_if.consumer     req,
  input  logic [Width-1:0] acc_i,
  output logic             result_valid_o,
  output logic [Width-1:0] result_o,
  output logic             acc_write_o
);

  // Lane must be buildable at this width
  if (Width < MinLaneWidth || Width > MaxLaneWidth) begin : g_width_check
    $error("valu_execute: lane width %0d outside %0d..%0d", Width, MinLaneWidth, MaxLaneWidth);
  end

  logic lane_valid;

  // No operation means nothing to execute
  assign lane_valid = req.valid && (req.op != OP_NONE);

  simd_lane #(
    .Width (Width)
  ) i_simd_lane (
    .operation_i       (req.op),
    .operation_valid_i (lane_valid),
    .op_s1_i           (req.src1),
    .op_s2_i           (req.src2),
    .op_d_i            (acc_i),
    .is_signed_i       (req.is_signed),
    .carry_i           (req.carry),
    .sew_i             (req.sew),
    .result_o          (result_o)
  );

  // Flags travel with the lane result
  assign result_valid_o = lane_valid;
  assign acc_write_o    = lane_valid & req.acc_write;

endmodule : valu_execute

/* rtl/valu_isa_pkg.sv */
// Operation enum, instruction word layout, function codes and accumulator reset value
package valu_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    OP_NONE,
    VADD, VSUB, VRSUB, VADC, VSBC, VMADC, VMSBC,
    VMIN, VMINU, VMAX, VMAXU,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VMUL, VMULH, VMULHU, VMULHSU,
    VMACC, VNMSAC, VMADD, VNMSUB
  } op_e;

  ////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////

  parameter int unsigned InstrWidth = 9;

  typedef logic [5:0] funct_t;

  // Bit 8 acc write, bits 7..6 SEW, bits 5..0 function code
  typedef struct packed {
    logic       acc_write;
    logic [1:0] sew;
    funct_t     funct;
  } instr_t;

  // Accumulator value after reset
  parameter int unsigned AccResetValue = 0;

  ////////////////////////////////////////////////////////////
  // Function codes
  ////////////////////////////////////////////////////////////

  // Add and subtract group
  parameter funct_t FunctVadd    = 6'h00;
  parameter funct_t FunctVsub    = 6'h01;
  parameter funct_t FunctVrsub   = 6'h02;
  parameter funct_t FunctVadc    = 6'h03;
  parameter funct_t FunctVsbc    = 6'h04;
  parameter funct_t FunctVmadc   = 6'h05;
  parameter funct_t FunctVmsbc   = 6'h06;
  // Compare
  parameter funct_t FunctVmin    = 6'h08;
  parameter funct_t FunctVminu   = 6'h09;
  parameter funct_t FunctVmax    = 6'h0a;
  parameter funct_t FunctVmaxu   = 6'h0b;
  // Logic and shifts
  parameter funct_t FunctVand    = 6'h10;
  parameter funct_t FunctVor     = 6'h11;
  parameter funct_t FunctVxor    = 6'h12;
  parameter funct_t FunctVsll    = 6'h18;
  parameter funct_t FunctVsrl    = 6'h19;
  parameter funct_t FunctVsra    = 6'h1a;
  // Multiply and multiply-accumulate
  parameter funct_t FunctVmul    = 6'h20;
  parameter funct_t FunctVmulh   = 6'h21;
  parameter funct_t FunctVmulhu  = 6'h22;
  parameter funct_t FunctVmulhsu = 6'h23;
  parameter funct_t FunctVmacc   = 6'h28;
  parameter funct_t FunctVnmsac  = 6'h29;
  parameter funct_t FunctVmadd   = 6'h2a;
  parameter funct_t FunctVnmsub  = 6'h2b;

endpackage : valu_isa_pkg

/* rtl/valu_req_if.sv */
// Decoded request interface between decode and execute stages
interface valu_req_if import valu_isa_pkg::*; import vec_width_pkg::*; #(
  parameter int unsigned Width = 32
);

  logic             valid;
  op_e              op;
  vew_e             sew;
  logic             is_signed;
  logic             carry;
  logic             acc_write;
  logic [Width-1:0] src1;
  logic [Width-1:0] src2;

  // Decoder side
  modport producer (
    output valid, op, sew, is_signed, carry, acc_write, src1, src2
  );

  // Execute side, always accepts
  modport consumer (
    input valid, op, sew, is_signed, carry, acc_write, src1, src2
  );

endinterface : valu_req_if

/* rtl/valu_result.sv */
// Result stage with response register, illegal flag and accumulator
module valu_result import valu_isa_pkg::*; #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             result_valid_i,
  input  logic [Width-1:0] result_i,
  input  logic             acc_write_i,
  input  logic             illegal_i,
  output logic [Width-1:0] acc_o,
  output logic             result_valid_o,
  output logic [Width-1:0] result_o,
  output logic             illegal_o
);

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : flag_reg
    if (reset_i) begin
      result_valid_o <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      result_valid_o <= result_valid_i;
      illegal_o      <= illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin : data_reg
    if (result_valid_i) begin
      result_o <= result_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  // Written on the edge that presents the result
  always_ff @(posedge clk_i) begin : acc_reg
    if (reset_i) begin
      acc_o <= Width'(AccResetValue);
    end else if (result_valid_i && acc_write_i) begin
      acc_o <= result_i;
    end
  end

  a_resp_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(result_valid_o && illegal_o)
  ) else $error("valu_result: result and illegal presented together");

  // Illegal and non-writing instructions leave the accumulator alone
  a_acc_write_only: assert property (
    @(posedge clk_i) disable iff (reset_i)
      $changed(acc_o) |-> $past(result_valid_i && acc_write_i)
  ) else $error("valu_result: accumulator changed without a write");

endmodule : valu_result

/* rtl/valu_top.sv */
// Top level with decode, execute and result stages
module valu_top import valu_isa_pkg::*; #(
  parameter int unsigned Width = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [InstrWidth-1:0] instr_i,
  input  logic [Width-1:0]      src1_i,
  input  logic [Width-1:0]      src2_i,
  input  logic                  carry_i,
  output logic                  result_valid_o,
  output logic [Width-1:0]      result_o,
  output logic                  illegal_o
);

  valu_req_if #(.Width(Width)) req_if ();

  logic             dec_illegal;
  logic             exe_valid;
  logic [Width-1:0] exe_result;
  logic             exe_acc_write;
  logic [Width-1:0] acc;

  valu_decoder #(
    .Width (Width)
  ) i_valu_decoder (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .src1_i        (src1_i),
    .src2_i        (src2_i),
    .carry_i       (carry_i),
    .req           (req_if.producer),
    .illegal_o     (dec_illegal)
  );

  valu_execute #(
    .Width (Width)
  ) i_valu_execute (
    .req            (req_if.consumer),
    .acc_i          (acc),
    .result_valid_o (exe_valid),
    .result_o       (exe_result),
    .acc_write_o    (exe_acc_write)
  );

  valu_result #(
    .Width (Width)
  ) i_valu_result (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .result_valid_i (exe_valid),
    .result_i       (exe_result),
    .acc_write_i    (exe_acc_write),
    .illegal_i      (dec_illegal),
    .acc_o          (acc),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

endmodule : valu_top

/* rtl/vec_width_pkg.sv */
// Element width type, lane width limits and SEW size helper
package vec_width_pkg;

  ////////////////////////////////////////////////////////////
  // Element width
  ////////////////////////////////////////////////////////////

  // SEW encoding as carried in the instruction word
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2,
    EW_64 = 2'd3
  } vew_e;

  ////////////////////////////////////////////////////////////
  // Lane limits
  ////////////////////////////////////////////////////////////

  // Narrowest and widest lane that can be built
  parameter int unsigned MinLaneWidth = 8;
  parameter int unsigned MaxLaneWidth = 64;

  // Element size in bits for a SEW code
  function automatic int unsigned sew_bits(vew_e sew);
    return 32'd8 << sew;
  endfunction

endpackage : vec_width_pkg

/* tb/tb_clock_gen.sv */
// Free-running clock source for the testbench
module tb_clock_gen #(
  parameter int unsigned Period = 8
) (
  output logic clk_o
);

  // Half period per toggle
  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

endmodule : tb_clock_gen

/* tb/tb_valu.sv */
// Testbench for the vector ALU slice with file-driven stimulus and response checks
module tb_valu;

  localparam int unsigned Width        = 32;
  localparam int unsigned InstrBits    = 9;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned DrainTimeout = 200;

  logic                 clk_i;
  logic                 reset_i;
  logic                 instr_valid_i;
  logic [InstrBits-1:0] instr_i;
  logic [Width-1:0]     src1_i;
  logic [Width-1:0]     src2_i;
  logic                 carry_i;
  logic                 result_valid_o;
  logic [Width-1:0]     result_o;
  logic                 illegal_o;

  // Expected responses in issue order
  logic [Width-1:0] exp_data_q[$];
  logic             exp_illegal_q[$];

  int unsigned errors;
  int unsigned checked;
  integer      seed;

  tb_clock_gen #(
    .Period (8)
  ) i_tb_clock_gen (
    .clk_o (clk_i)
  );

  valu_top #(
    .Width (Width)
  ) i_valu_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .src1_i         (src1_i),
    .src2_i         (src2_i),
    .carry_i        (carry_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  task automatic check_value(input string what, input logic [Width-1:0] actual,
                             input logic [Width-1:0] expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, sample on the falling one
  always @(negedge clk_i) begin
    if (!reset_i && (result_valid_o || illegal_o)) begin
      if (exp_illegal_q.size() == 0) begin
        $display("Unexpected response at time %0t with no instruction outstanding", $time);
        errors++;
      end else begin
        logic [Width-1:0] exp_data;
        logic             exp_illegal;
        exp_data    = exp_data_q.pop_front();
        exp_illegal = exp_illegal_q.pop_front();
        check_value("result valid", Width'(result_valid_o), Width'(!exp_illegal));
        check_value("illegal flag", Width'(illegal_o), Width'(exp_illegal));
        if (!exp_illegal) begin
          check_value("result", result_o, exp_data);
        end
        checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    integer               fd;
    logic [1023:0]        line;
    logic [InstrBits-1:0] v_instr;
    logic [Width-1:0]     v_src1;
    logic [Width-1:0]     v_src2;
    logic                 v_carry;
    logic [Width-1:0]     v_result;
    logic                 v_illegal;
    int unsigned          idle;
    int unsigned          vectors;
    int unsigned          wait_cycles;

    errors        = 0;
    checked       = 0;
    vectors       = 0;
    seed          = 78;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    src1_i        = '0;
    src2_i        = '0;
    carry_i       = 1'b0;

    fd = $fopen("tb/valu_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/valu_vectors.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      repeat (ResetCycles) @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i);

      while ($fgets(line, fd) != 0) begin
        // Comment and blank lines parse no fields
        if ($sscanf(line, "%h %h %h %h %h %h", v_instr, v_src1, v_src2, v_carry,
                    v_result, v_illegal) == 6) begin
          instr_valid_i <= 1'b1;
          instr_i       <= v_instr;
          src1_i        <= v_src1;
          src2_i        <= v_src2;
          carry_i       <= v_carry;
          exp_data_q.push_back(v_result);
          exp_illegal_q.push_back(v_illegal);
          vectors++;
          @(posedge clk_i);
          idle = $unsigned($random(seed)) % 3;
          if (idle > 0) begin
            instr_valid_i <= 1'b0;
            repeat (idle) @(posedge clk_i);
          end
        end
      end
      instr_valid_i <= 1'b0;
      $fclose(fd);

      if (vectors == 0) begin
        $display("The vector file held no usable vectors");
        errors++;
      end

      // Drain outstanding responses
      wait_cycles = 0;
      while (exp_illegal_q.size() != 0 && wait_cycles < DrainTimeout) begin
        @(posedge clk_i);
        wait_cycles++;
      end

      if (exp_illegal_q.size() != 0) begin
        $display("Timeout: responses stopped arriving with %0d still outstanding",
                 exp_illegal_q.size());
        $display("** FAIL **");
        $finish;
      end else begin
        $display("Vectors %0d, responses checked %0d, errors %0d", vectors, checked, errors);
        if (errors == 0) begin
          $display("** PASS **");
        end else begin
          $display("** FAIL **");
        end
        $finish;
      end
    end
  end

endmodule : tb_valu

/* tb/valu_vectors.txt */
// Columns in hex: instr src1 src2 carry expected_result expected_illegal
// Instr bit 8 acc write, bits 7..6 SEW, bits 5..0 function code
080 7fffffff 00000001 0 80000000 0
080 00000001 00000002 1 00000003 0
081 00000010 00000100 0 000000f0 0
082 00000010 00000100 0 ffffff10 0
083 ffffffff 00000001 1 00000001 0
084 00000001 00000005 1 00000003 0
085 ffffffff 00000000 1 00000001 0
085 ffffffff 00000000 0 00000000 0
086 00000001 00000001 1 00000001 0
088 fffffff0 00000010 0 fffffff0 0
089 fffffff0 00000010 0 00000010 0
08a fffffff0 00000010 0 00000010 0
08b fffffff0 00000010 0 fffffff0 0
090 f0f0ff00 0ff0f0f0 0 00f0f000 0
091 f0f0ff00 0ff0f0f0 0 fff0fff0 0
092 f0f0ff00 0ff0f0f0 0 ff000ff0 0
018 0000000b 12345681 0 00000408 0
019 0000000a abcd00f0 0 0000003c 0
01a 00000002 00000080 0 ffffffe0 0
058 00000014 ffff1234 0 00012340 0
059 00000011 00018000 0 00004000 0
05a 00000004 0000f000 0 ffffff00 0
098 00000024 0000000f 0 000000f0 0
09a 00000008 80000000 0 ff800000 0
0a0 00010001 00010001 0 00020001 0
0a1 fffffffe 00000003 0 ffffffff 0
0a2 fffffffe 00000003 0 00000002 0
0a3 fffffffe ffffffff 0 fffffffe 0
0a1 80000000 80000000 0 40000000 0
087 00000001 00000001 0 00000000 1
0c0 00000001 00000001 0 00000000 1
13f 00000001 00000001 0 00000000 1
1a8 00000003 00000004 0 0000000c 0
1a9 00000002 00000001 0 0000000a 0
1e8 00000007 00000007 0 00000000 1
1aa 00000003 00000005 0 00000023 0
1bf 00000009 00000009 0 00000000 1
1ab 00000002 00000100 0 000000ba 0
0a8 00000001 00000001 0 000000bb 0
1a8 00000010 00000010 0 000001ba 0
